/* adxl362_pkg.sv */
// ADXL362 shared definitions
`default_nettype none

package adxl362_pkg;

   localparam int AXIS_WIDTH   = 12;
   localparam int THRESH_WIDTH = 11;
   localparam int ADDR_WIDTH   = 6;
   localparam int BYTE_WIDTH   = 8;

   localparam logic [BYTE_WIDTH-1:0] SOFT_RESET_KEY = 8'h52;

   // STATUS bit positions
   localparam int ST_DATA_READY = 0;
   localparam int ST_ACT        = 4;
   localparam int ST_INACT      = 5;
   localparam int ST_AWAKE      = 6;

   // ACT_INACT_CTL bit positions
   localparam int ACT_EN   = 0;
   localparam int INACT_EN = 2;

   // Polarity bit in INTMAP1 and INTMAP2
   localparam int INT_LOW = 7;

   typedef enum logic [ADDR_WIDTH-1:0] {
      DEVID_AD       = 6'h00, DEVID_MST      = 6'h01, PARTID         = 6'h02,
      REVID          = 6'h03, XDATA          = 6'h08, YDATA          = 6'h09,
      ZDATA          = 6'h0A, STATUS         = 6'h0B, FIFO_ENTRIES_L = 6'h0C,
      FIFO_ENTRIES_H = 6'h0D, XDATA_L        = 6'h0E, XDATA_H        = 6'h0F,
      YDATA_L        = 6'h10, YDATA_H        = 6'h11, ZDATA_L        = 6'h12,
      ZDATA_H        = 6'h13, TEMP_L         = 6'h14, TEMP_H         = 6'h15,
      SOFT_RESET     = 6'h1F, THRESH_ACT_L   = 6'h20, THRESH_ACT_H   = 6'h21,
      TIME_ACT       = 6'h22, THRESH_INACT_L = 6'h23, THRESH_INACT_H = 6'h24,
      TIME_INACT_L   = 6'h25, TIME_INACT_H   = 6'h26, ACT_INACT_CTL  = 6'h27,
      FIFO_CONTROL   = 6'h28, FIFO_SAMPLES   = 6'h29, INTMAP1        = 6'h2A,
      INTMAP2        = 6'h2B, FILTER_CTL     = 6'h2C, POWER_CTL      = 6'h2D,
      SELF_TEST      = 6'h2E
   } reg_addr_e;

   typedef enum logic [BYTE_WIDTH-1:0] {
      CMD_WRITE = 8'h0A,
      CMD_READ  = 8'h0B,
      CMD_FIFO  = 8'h0D
   } spi_cmd_e;

   typedef enum logic [2:0] {
      IDLE,
      COMMAND,
      ADDRESS,
      DATA,
      IGNORE
   } spi_state_e;

endpackage

`default_nettype wire

/* adxl362_spi.sv */
// ADXL362 SPI slave
`timescale 1ns/100ps
`default_nettype none

module adxl362_spi #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                               clk_16mhz,
   input  logic                               rst,
   input  logic                               sclk,
   input  logic                               cs_n,
   input  logic                               mosi,
   input  logic [adxl362_pkg::BYTE_WIDTH-1:0] rd_data,
   output logic                               miso,
   output logic [adxl362_pkg::ADDR_WIDTH-1:0] reg_addr,
   output logic [adxl362_pkg::BYTE_WIDTH-1:0] wr_data,
   output logic                               wr_strobe,
   output logic                               rd_strobe
);
   import adxl362_pkg::*;

   // One extra flop past the synchronizer lines the pins up with the edge strobes
   logic [SYNC_STAGES:0] sclk_sync;
   logic [SYNC_STAGES:0] mosi_sync;
   logic [SYNC_STAGES:0] cs_sync;

   logic cs_s;
   logic sclk_rise;
   logic sclk_fall;
   logic mosi_bit;

   spi_state_e                state;
   logic [2:0]                bit_cnt;
   logic [BYTE_WIDTH-2:0]     rx_shift;
   logic [BYTE_WIDTH-1:0]     rx_byte;
   logic [BYTE_WIDTH-1:0]     tx_shift;
   logic                      cmd_read;
   logic                      byte_done;

   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         sclk_sync <= '0;
         mosi_sync <= '0;
         cs_sync   <= '1;
         sclk_rise <= 1'b0;
         sclk_fall <= 1'b0;
      end else begin
         sclk_sync <= {sclk_sync[SYNC_STAGES-1:0], sclk};
         mosi_sync <= {mosi_sync[SYNC_STAGES-1:0], mosi};
         cs_sync   <= {cs_sync[SYNC_STAGES-1:0], cs_n};
         sclk_rise <= sclk_sync[SYNC_STAGES-1] & ~sclk_sync[SYNC_STAGES];
         sclk_fall <= ~sclk_sync[SYNC_STAGES-1] & sclk_sync[SYNC_STAGES];
      end
   end

   assign cs_s      = cs_sync[SYNC_STAGES];
   assign mosi_bit  = mosi_sync[SYNC_STAGES];
   assign rx_byte   = {rx_shift, mosi_bit};
   assign byte_done = sclk_rise && (bit_cnt == 3'd7);

   // Bit counter and receive shifter
   always_ff @(posedge clk_16mhz) begin
      if (rst || cs_s) begin
         bit_cnt  <= '0;
         rx_shift <= '0;
      end else if (sclk_rise) begin
         bit_cnt  <= bit_cnt + 3'd1;
         rx_shift <= rx_byte[BYTE_WIDTH-2:0];
      end
   end

   // Command, address and data phases
   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         state     <= IDLE;
         cmd_read  <= 1'b0;
         reg_addr  <= '0;
         wr_data   <= '0;
         wr_strobe <= 1'b0;
         rd_strobe <= 1'b0;
      end else begin
         wr_strobe <= 1'b0;
         rd_strobe <= 1'b0;
         // Advance after each written byte
         if (wr_strobe) begin
            reg_addr <= reg_addr + 1'b1;
         end
         if (cs_s) begin
            state <= IDLE;
         end else begin
            case (state)
               IDLE: state <= COMMAND;
               COMMAND: begin
                  if (byte_done) begin
                     case (rx_byte)
                        CMD_WRITE: begin
                           cmd_read <= 1'b0;
                           state    <= ADDRESS;
                        end
                        CMD_READ: begin
                           cmd_read <= 1'b1;
                           state    <= ADDRESS;
                        end
                        CMD_FIFO: state <= IGNORE;
                        default:  state <= IGNORE;
                     endcase
                  end
               end
               ADDRESS: begin
                  if (byte_done) begin
                     reg_addr  <= rx_byte[ADDR_WIDTH-1:0];
                     rd_strobe <= cmd_read;
                     state     <= DATA;
                  end
               end
               DATA: begin
                  if (byte_done) begin
                     if (cmd_read) begin
                        // Prefetch for the next byte
                        reg_addr  <= reg_addr + 1'b1;
                        rd_strobe <= 1'b1;
                     end else begin
                        wr_data   <= rx_byte;
                        wr_strobe <= 1'b1;
                     end
                  end
               end
               default: state <= IGNORE;
            endcase
         end
      end
   end

   // Read data goes out MSB first on falling edges
   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         tx_shift <= '0;
         miso     <= 1'b0;
      end else if (rd_strobe) begin
         tx_shift <= rd_data;
      end else if (sclk_fall && !cs_s) begin
         miso     <= tx_shift[BYTE_WIDTH-1];
         tx_shift <= {tx_shift[BYTE_WIDTH-2:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

/* adxl362_regs.sv */
// ADXL362 register file
`timescale 1ns/100ps
`default_nettype none

module adxl362_regs (
   input  logic                                 clk_16mhz,
   input  logic                                 rst,
   input  logic [adxl362_pkg::ADDR_WIDTH-1:0]   reg_addr,
   input  logic [adxl362_pkg::BYTE_WIDTH-1:0]   wr_data,
   input  logic                                 wr_strobe,
   input  logic                                 rd_strobe,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   xdata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   ydata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   zdata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   temperature,
   input  logic [adxl362_pkg::BYTE_WIDTH-1:0]   status,
   output logic [adxl362_pkg::BYTE_WIDTH-1:0]   rd_data,
   output logic [adxl362_pkg::THRESH_WIDTH-1:0] threshold_active,
   output logic [7:0]                           time_active,
   output logic [adxl362_pkg::THRESH_WIDTH-1:0] threshold_inactive,
   output logic [15:0]                          time_inactive,
   output logic [7:0]                           act_inact_ctrl,
   output logic [7:0]                           intmap1,
   output logic [7:0]                           intmap2,
   output logic                                 status_clear
);
   import adxl362_pkg::*;

   logic [7:0] fifo_ctrl;
   logic [7:0] fifo_samples;
   logic [7:0] filter_ctrl;
   logic [7:0] power_ctrl;
   logic       self_test;
   logic       soft_reset;

   assign soft_reset = wr_strobe && (reg_addr == SOFT_RESET) && (wr_data == SOFT_RESET_KEY);

   // Read mux
   always_comb begin
      case (reg_addr)
         DEVID_AD:       rd_data = 8'hAD;
         DEVID_MST:      rd_data = 8'h1D;
         PARTID:         rd_data = 8'hF2;
         REVID:          rd_data = 8'h01;
         XDATA:          rd_data = xdata[11:4];
         YDATA:          rd_data = ydata[11:4];
         ZDATA:          rd_data = zdata[11:4];
         STATUS:         rd_data = status;
         XDATA_L:        rd_data = xdata[7:0];
         XDATA_H:        rd_data = {4'h0, xdata[11:8]};
         YDATA_L:        rd_data = ydata[7:0];
         YDATA_H:        rd_data = {4'h0, ydata[11:8]};
         ZDATA_L:        rd_data = zdata[7:0];
         ZDATA_H:        rd_data = {4'h0, zdata[11:8]};
         TEMP_L:         rd_data = temperature[7:0];
         TEMP_H:         rd_data = {4'h0, temperature[11:8]};
         THRESH_ACT_L:   rd_data = threshold_active[7:0];
         THRESH_ACT_H:   rd_data = {5'h00, threshold_active[10:8]};
         TIME_ACT:       rd_data = time_active;
         THRESH_INACT_L: rd_data = threshold_inactive[7:0];
         THRESH_INACT_H: rd_data = {5'h00, threshold_inactive[10:8]};
         TIME_INACT_L:   rd_data = time_inactive[7:0];
         TIME_INACT_H:   rd_data = time_inactive[15:8];
         ACT_INACT_CTL:  rd_data = act_inact_ctrl;
         FIFO_CONTROL:   rd_data = fifo_ctrl;
         FIFO_SAMPLES:   rd_data = fifo_samples;
         INTMAP1:        rd_data = intmap1;
         INTMAP2:        rd_data = intmap2;
         FILTER_CTL:     rd_data = filter_ctrl;
         POWER_CTL:      rd_data = power_ctrl;
         SELF_TEST:      rd_data = {7'h00, self_test};
         // FIFO entries and soft reset read as zero
         default:        rd_data = 8'h00;
      endcase
   end

   always_ff @(posedge clk_16mhz) begin
      if (rst || soft_reset) begin
         threshold_active   <= '0;
         time_active        <= '0;
         threshold_inactive <= '0;
         time_inactive      <= '0;
         act_inact_ctrl     <= '0;
         fifo_ctrl          <= '0;
         fifo_samples       <= 8'h80;
         intmap1            <= '0;
         intmap2            <= '0;
         filter_ctrl        <= 8'h13;
         power_ctrl         <= '0;
         self_test          <= 1'b0;
      end else if (wr_strobe) begin
         case (reg_addr)
            THRESH_ACT_L:   threshold_active[7:0]    <= wr_data;
            THRESH_ACT_H:   threshold_active[10:8]   <= wr_data[2:0];
            TIME_ACT:       time_active              <= wr_data;
            THRESH_INACT_L: threshold_inactive[7:0]  <= wr_data;
            THRESH_INACT_H: threshold_inactive[10:8] <= wr_data[2:0];
            TIME_INACT_L:   time_inactive[7:0]       <= wr_data;
            TIME_INACT_H:   time_inactive[15:8]      <= wr_data;
            ACT_INACT_CTL:  act_inact_ctrl           <= wr_data;
            FIFO_CONTROL:   fifo_ctrl                <= wr_data;
            FIFO_SAMPLES:   fifo_samples             <= wr_data;
            INTMAP1:        intmap1                  <= wr_data;
            INTMAP2:        intmap2                  <= wr_data;
            FILTER_CTL:     filter_ctrl              <= wr_data;
            POWER_CTL:      power_ctrl               <= wr_data;
            SELF_TEST:      self_test                <= wr_data[0];
            default: ;
         endcase
      end
   end

   // Reading STATUS clears the sticky bits
   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         status_clear <= 1'b0;
      end else begin
         status_clear <= rd_strobe && (reg_addr == STATUS);
      end
   end

endmodule

`default_nettype wire

/* adxl362_activity.sv */
// ADXL362 activity and inactivity detector
`timescale 1ns/100ps
`default_nettype none

module adxl362_activity (
   input  logic                                 clk_16mhz,
   input  logic                                 rst,
   input  logic                                 sample_strobe,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   xdata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   ydata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0]   zdata,
   input  logic [adxl362_pkg::THRESH_WIDTH-1:0] threshold_active,
   input  logic [7:0]                           time_active,
   input  logic [adxl362_pkg::THRESH_WIDTH-1:0] threshold_inactive,
   input  logic [15:0]                          time_inactive,
   input  logic [7:0]                           act_inact_ctrl,
   output logic                                 act_event,
   output logic                                 inact_event
);
   import adxl362_pkg::*;

   // Magnitude of a two's complement sample, 0x800 included
   function automatic logic [AXIS_WIDTH-1:0] magnitude(input logic [AXIS_WIDTH-1:0] value);
      return value[AXIS_WIDTH-1] ? (~value + 1'b1) : value;
   endfunction

   logic [AXIS_WIDTH-1:0] abs_x;
   logic [AXIS_WIDTH-1:0] abs_y;
   logic [AXIS_WIDTH-1:0] abs_z;
   logic [AXIS_WIDTH-1:0] thr_act;
   logic [AXIS_WIDTH-1:0] thr_inact;
   logic                  act_sample;
   logic                  inact_sample;
   logic [7:0]            act_target;
   logic [15:0]           inact_target;
   logic [7:0]            act_cnt;
   logic [15:0]           inact_cnt;

   assign abs_x     = magnitude(xdata);
   assign abs_y     = magnitude(ydata);
   assign abs_z     = magnitude(zdata);
   assign thr_act   = {1'b0, threshold_active};
   assign thr_inact = {1'b0, threshold_inactive};

   assign act_sample   = (abs_x > thr_act) || (abs_y > thr_act) || (abs_z > thr_act);
   assign inact_sample = (abs_x < thr_inact) && (abs_y < thr_inact) && (abs_z < thr_inact);

   // Zero time behaves as one sample
   assign act_target   = (time_active == '0) ? 8'd1 : time_active;
   assign inact_target = (time_inactive == '0) ? 16'd1 : time_inactive;

   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         act_cnt     <= '0;
         inact_cnt   <= '0;
         act_event   <= 1'b0;
         inact_event <= 1'b0;
      end else begin
         act_event   <= 1'b0;
         inact_event <= 1'b0;
         if (sample_strobe) begin
            // Any break in the run restarts the count
            if (act_inact_ctrl[ACT_EN] && act_sample) begin
               if (act_cnt >= act_target - 8'd1) begin
                  act_event <= 1'b1;
                  act_cnt   <= '0;
               end else begin
                  act_cnt <= act_cnt + 8'd1;
               end
            end else begin
               act_cnt <= '0;
            end
            if (act_inact_ctrl[INACT_EN] && inact_sample) begin
               if (inact_cnt >= inact_target - 16'd1) begin
                  inact_event <= 1'b1;
                  inact_cnt   <= '0;
               end else begin
                  inact_cnt <= inact_cnt + 16'd1;
               end
            end else begin
               inact_cnt <= '0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* adxl362_int.sv */
// ADXL362 status and interrupt combiner
`timescale 1ns/100ps
`default_nettype none

module adxl362_int (
   input  logic                               clk_16mhz,
   input  logic                               rst,
   input  logic                               sample_strobe,
   input  logic                               act_event,
   input  logic                               inact_event,
   input  logic                               status_clear,
   input  logic [7:0]                         intmap1,
   input  logic [7:0]                         intmap2,
   output logic [adxl362_pkg::BYTE_WIDTH-1:0] status,
   output logic                               int1,
   output logic                               int2
);
   import adxl362_pkg::*;

   logic data_ready;
   logic act_flag;
   logic inact_flag;
   logic awake;

   // A new event wins over a clear in the same cycle
   always_ff @(posedge clk_16mhz) begin
      if (rst) begin
         data_ready <= 1'b0;
         act_flag   <= 1'b0;
         inact_flag <= 1'b0;
         awake      <= 1'b0;
      end else begin
         data_ready <= sample_strobe | (data_ready & ~status_clear);
         act_flag   <= act_event | (act_flag & ~status_clear);
         inact_flag <= inact_event | (inact_flag & ~status_clear);
         if (act_event) begin
            awake <= 1'b1;
         end else if (inact_event) begin
            awake <= 1'b0;
         end
      end
   end

   always_comb begin
      status                = '0;
      status[ST_DATA_READY] = data_ready;
      status[ST_ACT]        = act_flag;
      status[ST_INACT]      = inact_flag;
      status[ST_AWAKE]      = awake;
   end

   assign int1 = (|(intmap1[6:0] & status[6:0])) ^ intmap1[INT_LOW];
   assign int2 = (|(intmap2[6:0] & status[6:0])) ^ intmap2[INT_LOW];

endmodule

`default_nettype wire

/* adxl362_top.sv */
// ADXL362 digital model top level
`timescale 1ns/100ps
`default_nettype none

module adxl362_top #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                               clk_16mhz,
   input  logic                               rst,
   input  logic                               sclk,
   input  logic                               cs_n,
   input  logic                               mosi,
   input  logic                               sample_strobe,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0] xdata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0] ydata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0] zdata,
   input  logic [adxl362_pkg::AXIS_WIDTH-1:0] temperature,
   output logic                               miso,
   output logic                               int1,
   output logic                               int2
);
   import adxl362_pkg::*;

   logic [ADDR_WIDTH-1:0]   reg_addr;
   logic [BYTE_WIDTH-1:0]   wr_data;
   logic [BYTE_WIDTH-1:0]   rd_data;
   logic                    wr_strobe;
   logic                    rd_strobe;
   logic [THRESH_WIDTH-1:0] threshold_active;
   logic [7:0]              time_active;
   logic [THRESH_WIDTH-1:0] threshold_inactive;
   logic [15:0]             time_inactive;
   logic [7:0]              act_inact_ctrl;
   logic [7:0]              intmap1;
   logic [7:0]              intmap2;
   logic                    status_clear;
   logic [BYTE_WIDTH-1:0]   status;
   logic                    act_event;
   logic                    inact_event;

   adxl362_spi #(
      .SYNC_STAGES(SYNC_STAGES)
   ) adxl362_spi_inst (
      .clk_16mhz, .rst, .sclk, .cs_n, .mosi, .rd_data,
      .miso, .reg_addr, .wr_data, .wr_strobe, .rd_strobe
   );

   adxl362_regs adxl362_regs_inst (
      .clk_16mhz, .rst, .reg_addr, .wr_data, .wr_strobe, .rd_strobe,
      .xdata, .ydata, .zdata, .temperature, .status,
      .rd_data, .threshold_active, .time_active, .threshold_inactive,
      .time_inactive, .act_inact_ctrl, .intmap1, .intmap2, .status_clear
   );

   adxl362_activity adxl362_activity_inst (
      .clk_16mhz, .rst, .sample_strobe, .xdata, .ydata, .zdata,
      .threshold_active, .time_active, .threshold_inactive, .time_inactive,
      .act_inact_ctrl, .act_event, .inact_event
   );

   adxl362_int adxl362_int_inst (
      .clk_16mhz, .rst, .sample_strobe, .act_event, .inact_event,
      .status_clear, .intmap1, .intmap2, .status, .int1, .int2
   );

endmodule

`default_nettype wire

/* adxl362_asserts.sv */
// ADXL362 bound assertions
`timescale 1ns/100ps
`default_nettype none

module adxl362_asserts (
   input logic clk_16mhz,
   input logic rst,
   input logic cs_n,
   input logic wr_strobe,
   input logic rd_strobe,
   input logic act_event,
   input logic inact_event,
   input logic int1,
   input logic int2
);

   strobe_exclusive: assert property (
      @(posedge clk_16mhz) disable iff (rst) !(wr_strobe && rd_strobe)
   ) else $error("wr_strobe and rd_strobe high in the same cycle");

   // Writes only happen inside an SPI frame
   write_in_frame: assert property (
      @(posedge clk_16mhz) disable iff (rst) wr_strobe |-> !cs_n
   ) else $error("wr_strobe high while cs_n is high");

   act_event_single: assert property (
      @(posedge clk_16mhz) disable iff (rst) act_event |=> !act_event
   ) else $error("act_event lasted more than one cycle");

   inact_event_single: assert property (
      @(posedge clk_16mhz) disable iff (rst) inact_event |=> !inact_event
   ) else $error("inact_event lasted more than one cycle");

   int_pins_known: assert property (
      @(posedge clk_16mhz) disable iff (rst) !$isunknown({int1, int2})
   ) else $error("int1 or int2 is unknown");

endmodule

`default_nettype wire

/* tb_adxl362.sv */
// ADXL362 model testbench
`timescale 1ns/100ps
`default_nettype none

module tb_adxl362;
   import adxl362_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int TEST_COUNT      = 6;
   localparam int CYCLES_PER_TEST = 2000;
   localparam int HALF_SCLK       = 4;

   logic        clk_16mhz = 1'b0;
   logic        rst;
   logic        sclk;
   logic        cs_n;
   logic        mosi;
   logic        sample_strobe;
   logic [11:0] xdata;
   logic [11:0] ydata;
   logic [11:0] zdata;
   logic [11:0] temperature;
   logic        miso;
   logic        int1;
   logic        int2;

   logic [7:0]  tx_buf [0:31];
   logic [7:0]  rx_buf [0:31];
   logic [7:0]  data_buf [0:31];
   logic [31:0] lcg_state = 32'd74;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   adxl362_top #(
      .SYNC_STAGES(2)
   ) adxl362_top_inst (
      .clk_16mhz, .rst, .sclk, .cs_n, .mosi, .sample_strobe,
      .xdata, .ydata, .zdata, .temperature, .miso, .int1, .int2
   );

   bind adxl362_top adxl362_asserts adxl362_asserts_inst (
      .clk_16mhz, .rst, .cs_n, .wr_strobe, .rd_strobe,
      .act_event, .inact_event, .int1, .int2
   );

   always #(CLK_PERIOD / 2) clk_16mhz = ~clk_16mhz;

   // Upper bits of the LCG are the usable ones
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // 10-bit signed value sign-extended to 12 bits
   function automatic logic [11:0] random_sample();
      logic [31:0] r;
      r = next_random();
      return {{2{r[25]}}, r[25:16]};
   endfunction

   // Magnitude strictly above limit, random sign
   function automatic logic [11:0] loud_sample(input logic [10:0] limit);
      logic [31:0] r;
      logic [11:0] mag;
      r   = next_random();
      mag = {1'b0, limit} + 12'd1 + {6'd0, r[21:16]};
      return r[31] ? (~mag + 12'd1) : mag;
   endfunction

   // Magnitude strictly below limit, random sign
   function automatic logic [11:0] quiet_sample(input logic [10:0] limit);
      logic [31:0] r;
      logic [11:0] mag;
      r   = next_random();
      mag = {4'd0, r[23:16]} % {1'b0, limit};
      return r[31] ? (~mag + 12'd1) : mag;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_16mhz);
      #1;
   endtask

   // Mode 0 frame, miso taken just before each rising sclk
   task automatic spi_transfer(input int count);
      cs_n = 1'b0;
      wait_cycles(HALF_SCLK);
      for (int i = 0; i < count; i++) begin
         for (int b = 7; b >= 0; b--) begin
            mosi = tx_buf[i][b];
            wait_cycles(HALF_SCLK);
            rx_buf[i][b] = miso;
            sclk = 1'b1;
            wait_cycles(HALF_SCLK);
            sclk = 1'b0;
         end
      end
      wait_cycles(2 * HALF_SCLK);
      cs_n = 1'b1;
      wait_cycles(2 * HALF_SCLK);
   endtask

   task automatic write_regs(input logic [5:0] addr, input int count);
      tx_buf[0] = CMD_WRITE;
      tx_buf[1] = {2'b00, addr};
      for (int i = 0; i < count; i++) begin
         tx_buf[i + 2] = data_buf[i];
      end
      spi_transfer(count + 2);
   endtask

   task automatic read_regs(input logic [5:0] addr, input int count);
      tx_buf[0] = CMD_READ;
      tx_buf[1] = {2'b00, addr};
      for (int i = 0; i < count; i++) begin
         tx_buf[i + 2] = 8'h00;
      end
      spi_transfer(count + 2);
      for (int i = 0; i < count; i++) begin
         data_buf[i] = rx_buf[i + 2];
      end
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [7:0] value);
      data_buf[0] = value;
      write_regs(addr, 1);
   endtask

   task automatic read_reg(input logic [5:0] addr, output logic [7:0] value);
      read_regs(addr, 1);
      value = data_buf[0];
   endtask

   // One strobe, then time for the event and the status update
   task automatic apply_sample(input logic [11:0] x, input logic [11:0] y,
                               input logic [11:0] z);
      xdata         = x;
      ydata         = y;
      zdata         = z;
      sample_strobe = 1'b1;
      wait_cycles(1);
      sample_strobe = 1'b0;
      wait_cycles(3);
   endtask

   task automatic report_mismatch(input string name, input logic [7:0] expected,
                                  input logic [7:0] actual);
      $display("ERROR %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
      test_errors++;
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic test_id_read();
      logic [7:0] id_values [0:3];
      logic [7:0] value;
      id_values = '{8'hAD, 8'h1D, 8'hF2, 8'h01};
      read_regs(DEVID_AD, 4);
      for (int i = 0; i < 4; i++) begin
         if (data_buf[i] !== id_values[i]) begin
            report_mismatch("id_read", id_values[i], data_buf[i]);
         end
      end
      read_reg(FILTER_CTL, value);
      if (value !== 8'h13) begin
         report_mismatch("id_read", 8'h13, value);
      end
      read_reg(FIFO_SAMPLES, value);
      if (value !== 8'h80) begin
         report_mismatch("id_read", 8'h80, value);
      end
      finish_test("id_read");
   endtask

   task automatic test_register_access();
      logic [31:0] r;
      logic [7:0]  written [0:11];
      logic [7:0]  expected;
      for (int i = 0; i < 12; i++) begin
         r           = next_random();
         written[i]  = r[31:24];
         data_buf[i] = r[31:24];
      end
      write_regs(THRESH_ACT_L, 12);
      read_regs(THRESH_ACT_L, 12);
      for (int i = 0; i < 12; i++) begin
         // Offsets 1 and 4 are the 3-bit THRESH_H registers
         expected = (i == 1 || i == 4) ? (written[i] & 8'h07) : written[i];
         if (data_buf[i] !== expected) begin
            report_mismatch("register_access", expected, data_buf[i]);
         end
      end
      finish_test("register_access");
   endtask

   task automatic test_sample_readback();
      logic [7:0] expected [0:9];
      xdata       = random_sample();
      ydata       = random_sample();
      zdata       = random_sample();
      temperature = random_sample();
      read_regs(XDATA, 3);
      if (data_buf[0] !== xdata[11:4]) begin
         report_mismatch("sample_readback", xdata[11:4], data_buf[0]);
      end
      if (data_buf[1] !== ydata[11:4]) begin
         report_mismatch("sample_readback", ydata[11:4], data_buf[1]);
      end
      if (data_buf[2] !== zdata[11:4]) begin
         report_mismatch("sample_readback", zdata[11:4], data_buf[2]);
      end
      // FIFO entry count first, then the split sample registers
      expected = '{8'h00, 8'h00,
                   xdata[7:0], {4'h0, xdata[11:8]},
                   ydata[7:0], {4'h0, ydata[11:8]},
                   zdata[7:0], {4'h0, zdata[11:8]},
                   temperature[7:0], {4'h0, temperature[11:8]}};
      read_regs(FIFO_ENTRIES_L, 10);
      for (int i = 0; i < 10; i++) begin
         if (data_buf[i] !== expected[i]) begin
            report_mismatch("sample_readback", expected[i], data_buf[i]);
         end
      end
      finish_test("sample_readback");
   endtask

   task automatic test_activity();
      logic [10:0] threshold;
      logic [7:0]  value;
      logic [7:0]  expected;
      logic        expected_int;
      threshold    = 11'd200;
      data_buf[0]  = threshold[7:0];
      data_buf[1]  = {5'd0, threshold[10:8]};
      data_buf[2]  = 8'd3;
      data_buf[3]  = 8'h00;
      data_buf[4]  = 8'h00;
      data_buf[5]  = 8'h00;
      data_buf[6]  = 8'h00;
      data_buf[7]  = 8'd1 << ACT_EN;
      data_buf[8]  = 8'h00;
      data_buf[9]  = 8'h80;
      data_buf[10] = 8'd1 << ST_ACT;
      data_buf[11] = 8'h00;
      write_regs(THRESH_ACT_L, 12);
      for (int n = 1; n <= 3; n++) begin
         apply_sample(loud_sample(threshold), quiet_sample(threshold),
                      quiet_sample(threshold));
         expected_int = (n == 3);
         if (int1 !== expected_int) begin
            report_mismatch("activity", {7'h00, expected_int}, {7'h00, int1});
         end
      end
      expected = (8'd1 << ST_ACT) | (8'd1 << ST_AWAKE) | (8'd1 << ST_DATA_READY);
      read_reg(STATUS, value);
      if (value !== expected) begin
         report_mismatch("activity", expected, value);
      end
      // First read cleared the sticky bits, AWAKE stays
      expected = 8'd1 << ST_AWAKE;
      read_reg(STATUS, value);
      if (value !== expected) begin
         report_mismatch("activity", expected, value);
      end
      if (int1 !== 1'b0) begin
         report_mismatch("activity", 8'h00, {7'h00, int1});
      end
      finish_test("activity");
   endtask

   task automatic test_inactivity();
      logic [10:0] threshold;
      logic [7:0]  value;
      logic [7:0]  expected;
      logic        expected_int;
      threshold   = 11'd100;
      data_buf[0] = threshold[7:0];
      data_buf[1] = {5'd0, threshold[10:8]};
      data_buf[2] = 8'd2;
      data_buf[3] = 8'h00;
      data_buf[4] = 8'd1 << INACT_EN;
      data_buf[5] = 8'h00;
      data_buf[6] = 8'h80;
      data_buf[7] = 8'd1 << ST_ACT;
      data_buf[8] = (8'd1 << INT_LOW) | (8'd1 << ST_INACT);
      write_regs(THRESH_INACT_L, 9);
      if (int2 !== 1'b1) begin
         report_mismatch("inactivity", 8'h01, {7'h00, int2});
      end
      for (int n = 1; n <= 2; n++) begin
         apply_sample(quiet_sample(threshold), quiet_sample(threshold),
                      quiet_sample(threshold));
         // Active low, so the pin drops on the event
         expected_int = (n != 2);
         if (int2 !== expected_int) begin
            report_mismatch("inactivity", {7'h00, expected_int}, {7'h00, int2});
         end
      end
      expected = (8'd1 << ST_INACT) | (8'd1 << ST_DATA_READY);
      read_reg(STATUS, value);
      if (value !== expected) begin
         report_mismatch("inactivity", expected, value);
      end
      finish_test("inactivity");
   endtask

   task automatic test_soft_reset();
      logic [31:0] r;
      logic [7:0]  defaults [0:14];
      for (int i = 0; i < 15; i++) begin
         // Offset 9 is FIFO_SAMPLES, offset 12 is FILTER_CTL
         defaults[i] = (i == 9) ? 8'h80 : (i == 12) ? 8'h13 : 8'h00;
      end
      for (int i = 0; i < 15; i++) begin
         // Bit 0 always flips so even the narrow registers move
         r           = next_random();
         data_buf[i] = defaults[i] ^ (r[31:24] | 8'h01);
      end
      write_regs(THRESH_ACT_L, 15);
      write_reg(SOFT_RESET, SOFT_RESET_KEY);
      read_regs(THRESH_ACT_L, 15);
      for (int i = 0; i < 15; i++) begin
         if (data_buf[i] !== defaults[i]) begin
            report_mismatch("soft_reset", defaults[i], data_buf[i]);
         end
      end
      if (int1 !== 1'b0) begin
         report_mismatch("soft_reset", 8'h00, {7'h00, int1});
      end
      if (int2 !== 1'b0) begin
         report_mismatch("soft_reset", 8'h00, {7'h00, int2});
      end
      finish_test("soft_reset");
   endtask

   initial begin
      #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Timeout: tests still running after %0d cycles",
               TEST_COUNT * CYCLES_PER_TEST);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      rst           = 1'b1;
      sclk          = 1'b0;
      cs_n          = 1'b1;
      mosi          = 1'b0;
      sample_strobe = 1'b0;
      xdata         = '0;
      ydata         = '0;
      zdata         = '0;
      temperature   = '0;
      test_errors   = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      wait_cycles(2);
      rst = 1'b0;
      wait_cycles(2);
      test_id_read();
      test_register_access();
      test_sample_readback();
      test_activity();
      test_inactivity();
      test_soft_reset();
      $display("Tests run: %0d, passed: %0d, failed: %0d",
               tests_passed + tests_failed, tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* adxl362.f */
adxl362_pkg.sv
adxl362_spi.sv
adxl362_regs.sv
adxl362_activity.sv
adxl362_int.sv
adxl362_top.sv
adxl362_asserts.sv
tb_adxl362.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ADXL362 testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f adxl362.f --top-module tb_adxl362 -Mdir obj_dir \
   && ./obj_dir/Vtb_adxl362 > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "FAIL: build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: no summary in log"; exit 1; }
echo "PASS"
exit 0
